/* tb.f */
common/arcade_pkg.sv
rtl/control_mapper.sv
rtl/mouse_accum.sv
memory/rom_loader.sv
memory/mem_arbiter.sv
memory/game_mem.sv
rtl/arcade_io_top.sv
bench/tb_arcade_io.sv

/* Bender.yml */
package:
  name: arcade_io

sources:
  - common/arcade_pkg.sv
  - rtl/control_mapper.sv
  - rtl/mouse_accum.sv
  - memory/rom_loader.sv
  - memory/mem_arbiter.sv
  - memory/game_mem.sv
  - rtl/arcade_io_top.sv
  - target: test
    files:
      - bench/tb_arcade_io.sv

/* bench/tb_arcade_io.sv */
// Testbench for the arcade board glue
// Download, game memory port, control mapping, mice and advance pulse

module tb_arcade_io;
	timeunit 1ns;
	timeprecision 100ps;

	logic                   clk_sys;
	logic                   reset;
	logic                   dl_active;
	logic                   dl_wr;
	logic [7:0]             dl_index;
	logic [22:0]            dl_addr;
	logic [7:0]             dl_data;
	logic                   status_reset;
	logic                   button_reset;
	arcade_pkg::game_e      game;
	arcade_pkg::player_t    p1;
	arcade_pkg::player_t    p2;
	arcade_pkg::cab_ctrl_t  cab;
	logic                   auto_up;
	logic                   advance_req;
	logic                   mouse_strobe;
	logic                   mouse_idx;
	logic signed [8:0]      mouse_x;
	logic signed [8:0]      mouse_y;
	logic [7:0]             mouse_flags;
	logic                   gp_valid;
	logic [23:1]            gp_addr;
	logic                   gp_rom_sel;
	logic                   gp_we;
	logic [1:0]             gp_ds;
	logic [15:0]            gp_wdata;
	arcade_pkg::core_in_t   core_in;
	logic                   core_reset;
	logic                   rom_loaded;
	logic                   gp_ack;
	logic [15:0]            gp_rdata;

	logic [31:0]            lfsr = 32'h8768;
	logic [15:0]            shadow [0:131071]; // Expected memory contents
	logic [23:1]            rom_q [$];
	logic [9:0]             cmos_q [$];
	int                     checks = 0;
	int                     errors = 0;
	int                     t_checks;
	int                     t_errors;
	logic                   cmp_en = 1'b0;
	logic                   ref_sin_x;
	logic                   ref_sin_y;
	arcade_pkg::mouse_pos_t ref_m0;
	arcade_pkg::mouse_pos_t ref_m1;
	arcade_pkg::core_in_t   exp_in;

	arcade_io_top #(.adv_stretch(24'd16)) u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [16:0] rom_word(input logic [23:1] a);
		return {1'b0, a[16], ~a[16] & a[15], a[14:1]};
	endfunction

	function automatic logic [16:0] ram_word(input logic [23:1] a);
		return {1'b1, a[16:1]};
	endfunction

	function automatic logic [16:0] dl_word(input logic [7:0] idx, input logic [22:0] a);
		if ((idx == 8'h00 && a[22:10] == 13'h34) || idx == 8'hff)
			return arcade_pkg::cmos_base + {7'd0, a[9:0]};
		return a[16:0];
	endfunction

	function automatic logic [15:0] nibble_word(input logic [7:0] d);
		return {d[7:4], d[7:4], d[3:0], d[3:0]};
	endfunction

	// Expected core inputs, joystick bits active low
	function automatic arcade_pkg::core_in_t ref_core_in(input arcade_pkg::game_e g,
		input arcade_pkg::player_t a, input arcade_pkg::player_t b,
		input arcade_pkg::cab_ctrl_t c, input logic rst, input logic up, input logic adv,
		input logic sx, input logic sy, input arcade_pkg::mouse_pos_t ma,
		input arcade_pkg::mouse_pos_t mb);
		arcade_pkg::core_in_t e;
		logic                 coin;
		logic [3:0]           d1;
		logic [3:0]           d2;
		coin = c.coin1 | c.coin2;
		d1 = {a.right, a.left, a.down, a.up};
		d2 = {b.right, b.left, b.down, b.up};
		e = '0;
		e.sw = {6'd0, adv, up};
		e.ja = 8'hff;
		e.jb = 8'hff;
		e.btn = {c.two_players, c.one_player, coin, rst};
		e.an0 = 8'h80;
		e.an1 = 8'h80;
		e.an2 = 8'h80;
		e.an3 = 8'h80;
		e.orientation = 2'b10;
		case (g)
			arcade_pkg::robotron, arcade_pkg::splat: begin
				e.blitter_sc2 = (g == arcade_pkg::splat);
				e.btn = {c.one_player, c.two_players, coin, rst};
				e.ja = ~{a.fire_d | b.right, a.fire_c | b.left, a.fire_b | b.down,
					a.fire_a | b.up, d1}; // Second stick fires
				e.jb = e.ja;
			end
			arcade_pkg::joust: begin
				e.ja = ~{5'd0, a.fire_a, a.right, a.left};
				e.jb = ~{5'd0, b.fire_a, b.right, b.left};
			end
			arcade_pkg::bubbles: begin
				e.ja = ~{4'd0, d1};
				e.jb = ~{4'd0, d2};
			end
			arcade_pkg::stargate: begin
				e.ja = ~{a.fire_e, a.up, a.down, a.left | a.right, a.fire_d, a.fire_c,
					a.fire_b, a.fire_a};
				e.jb = ~{b.fire_e, b.up, b.down, b.left | b.right, b.fire_d, b.fire_c,
					b.fire_b, b.fire_a};
			end
			arcade_pkg::alienar: begin
				e.btn = {c.one_player, c.two_players, coin, rst};
				e.ja = ~{2'd0, a.fire_b, a.fire_a, d1};
				e.jb = ~{2'd0, b.fire_b, b.fire_a, d2};
			end
			arcade_pkg::sinistar: begin
				e.sinistar = 1'b1;
				e.speech_en = 1'b1;
				e.orientation = 2'b01;
				e.ja = {sx, 2'd0, |{d1[3:2], d2[3:2]}, sy, 2'd0, |{d1[1:0], d2[1:0]}};
				e.jb = e.ja;
			end
			arcade_pkg::playball: begin
				e.speech_en = 1'b1;
				e.orientation = 2'b01;
				e.btn = {2'd0, coin, rst};
				e.ja = ~{4'd0, c.two_players, a.right, a.left, c.one_player};
				e.jb = e.ja;
			end
			arcade_pkg::lottofun: begin
				e.btn = {c.one_player | a.fire_a, 1'b0, coin, rst};
				e.ja = ~{4'd0, d1};
			end
			arcade_pkg::speedball: begin
				e.speedball = 1'b1;
				e.ja = {a.fire_d, a.fire_c, a.fire_b, a.fire_a | ma.btn[0], d1};
				e.jb = {b.fire_d, b.fire_c, b.fire_b, b.fire_a | mb.btn[0], d2};
				e.an0 = {~ma.y[8], ma.y[7:1]};
				e.an1 = {~ma.x[8], ma.x[7:1]};
				e.an2 = {~mb.y[8], mb.y[7:1]};
				e.an3 = {~mb.x[8], mb.x[7:1]};
			end
			default: ;
		endcase
		return e;
	endfunction

	// Sinistar latches and trackball positions as the core should see them
	always @(posedge clk_sys) begin
		if (reset) begin
			ref_sin_x <= 1'b0;
			ref_sin_y <= 1'b0;
			ref_m0 <= '0;
			ref_m1 <= '0;
		end else begin
			if (p1.right | p2.right)
				ref_sin_x <= 1'b0;
			else if (p1.left | p2.left)
				ref_sin_x <= 1'b1;
			if (p1.up | p2.up)
				ref_sin_y <= 1'b0;
			else if (p1.down | p2.down)
				ref_sin_y <= 1'b1;
			if (mouse_strobe && !mouse_idx) begin
				ref_m0.x <= ref_m0.x + 10'(mouse_x);
				ref_m0.y <= ref_m0.y + 10'(mouse_y);
				ref_m0.btn <= mouse_flags[1:0];
			end
			if (mouse_strobe && mouse_idx) begin
				ref_m1.x <= ref_m1.x + 10'(mouse_x);
				ref_m1.y <= ref_m1.y + 10'(mouse_y);
				ref_m1.btn <= mouse_flags[1:0];
			end
		end
	end

	// Compare core_in mid cycle, between input drive and the next clock
	always @(negedge clk_sys) begin
		#2;
		if (cmp_en) begin
			exp_in = ref_core_in(game, p1, p2, cab, 1'b0, auto_up, 1'b0, ref_sin_x,
				ref_sin_y, ref_m0, ref_m1);
			checks++;
			assert (core_in === exp_in) else begin
				$display("ERROR at %0t ns: core_in for game %0d is %h, expected %h", $time,
					game, core_in, exp_in);
				errors++;
			end
		end
	end

	task automatic check_val(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic begin_test();
		t_checks = checks;
		t_errors = errors;
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - t_checks, errors - t_errors);
	endtask

	task automatic start_download();
		dl_active = 1'b1;
		@(negedge clk_sys);
	endtask

	// One byte every 4 cycles
	task automatic send_byte(input logic [7:0] idx, input logic [22:0] addr,
		input logic [7:0] data);
		check_val("core_reset during download", core_reset, 1);
		dl_index = idx;
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		@(negedge clk_sys);
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
		shadow[dl_word(idx, addr)] = nibble_word(data);
	endtask

	task automatic end_download();
		int n;
		dl_active = 1'b0;
		n = 0;
		while (core_reset && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		checks++;
		assert (!core_reset) else begin
			$display("core_reset still high 20 cycles after the download ended");
			errors++;
		end
		check_val("rom_loaded after download", rom_loaded, 1);
	endtask

	task automatic gp_access(input logic rom_sel, input logic [23:1] addr, input logic we,
		input logic [1:0] ds, input logic [15:0] wdata, output logic [15:0] rdata);
		int n;
		gp_rom_sel = rom_sel;
		gp_addr = addr;
		gp_we = we;
		gp_ds = ds;
		gp_wdata = wdata;
		gp_valid = 1'b1;
		@(negedge clk_sys);
		gp_valid = 1'b0;
		n = 0;
		while (!gp_ack && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		checks++;
		assert (gp_ack) else begin
			$display("No gp_ack within 20 cycles for game port address %h", addr);
			errors++;
		end
		rdata = gp_rdata;
		@(negedge clk_sys);
	endtask

	initial begin
		logic [23:1] a;
		logic [16:0] w;
		logic [15:0] d;
		logic [15:0] rd;
		logic [9:0]  off;
		logic [1:0]  ds;
		int          n;
		reset = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_index = 8'h00;
		dl_addr = '0;
		dl_data = 8'h00;
		status_reset = 1'b0;
		button_reset = 1'b0;
		game = arcade_pkg::robotron;
		p1 = '0;
		p2 = '0;
		cab = '0;
		auto_up = 1'b0;
		advance_req = 1'b0;
		mouse_strobe = 1'b0;
		mouse_idx = 1'b0;
		mouse_x = '0;
		mouse_y = '0;
		mouse_flags = 8'h00;
		gp_valid = 1'b0;
		gp_addr = '0;
		gp_rom_sel = 1'b0;
		gp_we = 1'b0;
		gp_ds = 2'b00;
		gp_wdata = 16'h0000;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;

		begin_test();
		check_val("core_reset after reset", core_reset, 1);
		check_val("rom_loaded after reset", rom_loaded, 0);
		start_download();
		for (int i = 0; i < 16; i++) begin
			a = 23'(rand_bits(23));
			rom_q.push_back(a);
			send_byte(8'h00, {6'd0, rom_word(a)}, 8'(rand_bits(8)));
		end
		end_download();
		foreach (rom_q[i]) begin
			gp_access(1'b1, rom_q[i], 1'b0, 2'b00, 16'h0000, rd);
			check_val("ROM read after download", rd, shadow[rom_word(rom_q[i])]);
		end
		end_test("test 1 download and reset release");

		begin_test();
		start_download();
		for (int i = 0; i < 16; i++) begin
			off = 10'(rand_bits(10));
			cmos_q.push_back(off);
			if (i % 2 == 0)
				send_byte(8'h00, {13'h34, off}, 8'(rand_bits(8)));
			else
				send_byte(8'hff, {13'(rand_bits(13)), off}, 8'(rand_bits(8)));
		end
		end_download();
		foreach (cmos_q[i]) begin
			w = arcade_pkg::cmos_base + {7'd0, cmos_q[i]};
			gp_access(1'b0, {7'(rand_bits(7)), w[15:0]}, 1'b0, 2'b00, 16'h0000, rd);
			check_val("CMOS read through RAM space", rd, shadow[w]);
		end
		end_test("test 2 CMOS remap");

		begin_test();
		for (int i = 0; i < 12; i++) begin
			a = 23'(rand_bits(23));
			w = ram_word(a);
			d = 16'(rand_bits(16));
			gp_access(1'b0, a, 1'b1, 2'b11, d, rd);
			shadow[w] = d;
			d = 16'(rand_bits(16));
			ds = 2'(rand_bits(2));
			gp_access(1'b0, a, 1'b1, ds, d, rd);
			if (ds[1])
				shadow[w][15:8] = d[15:8];
			if (ds[0])
				shadow[w][7:0] = d[7:0];
			gp_access(1'b0, a, 1'b0, 2'b00, 16'h0000, rd);
			check_val("RAM read after lane write", rd, shadow[w]);
		end
		end_test("test 3 RAM byte lanes");

		begin_test();
		cmp_en = 1'b1;
		for (int g = 0; g < 11; g++) begin
			game = arcade_pkg::game_e'(7'(g < 10 ? g : 12)); // Last one undefined
			repeat (8) begin
				p1 = 10'(rand_bits(10));
				p2 = 10'(rand_bits(10));
				cab = 4'(rand_bits(4));
				auto_up = 1'(rand_bits(1));
				@(negedge clk_sys);
			end
		end
		end_test("test 4 control mapping");

		begin_test();
		game = arcade_pkg::speedball;
		for (int i = 0; i < 16; i++) begin
			mouse_strobe = 1'b1;
			mouse_idx = 1'(rand_bits(1));
			mouse_x = 9'(rand_bits(9));
			mouse_y = 9'(rand_bits(9));
			mouse_flags = 8'(rand_bits(8));
			p1 = 10'(rand_bits(10));
			p2 = 10'(rand_bits(10));
			@(negedge clk_sys);
			mouse_strobe = 1'b0;
			@(negedge clk_sys);
		end
		cmp_en = 1'b0;
		end_test("test 5 mouse and analog");

		begin_test();
		check_val("advance before request", core_in.sw[1], 0);
		advance_req = 1'b1;
		@(negedge clk_sys);
		check_val("advance one cycle after request", core_in.sw[1], 1);
		n = 0;
		while (core_in.sw[1] && n < 100) begin
			@(negedge clk_sys);
			n++;
		end
		check_val("advance pulse length", n, 16);
		advance_req = 1'b0;
		end_test("test 6 advance pulse");

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* rtl/arcade_io_top.sv */
// Arcade board glue top level
// ROM download, shared game memory, core reset and control mapping

module arcade_io_top #(
	parameter logic [23:0] adv_stretch = 24'hfffff
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  logic [7:0]             dl_index,
	input  logic [22:0]            dl_addr,
	input  logic [7:0]             dl_data,
	input  logic                   status_reset,
	input  logic                   button_reset,
	input  arcade_pkg::game_e      game,
	input  arcade_pkg::player_t    p1,
	input  arcade_pkg::player_t    p2,
	input  arcade_pkg::cab_ctrl_t  cab,
	input  logic                   auto_up,
	input  logic                   advance_req,
	input  logic                   mouse_strobe,
	input  logic                   mouse_idx,
	input  logic signed [8:0]      mouse_x,
	input  logic signed [8:0]      mouse_y,
	input  logic [7:0]             mouse_flags,
	input  logic                   gp_valid,
	input  logic [23:1]            gp_addr,
	input  logic                   gp_rom_sel,
	input  logic                   gp_we,
	input  logic [1:0]             gp_ds,
	input  logic [15:0]            gp_wdata,
	output arcade_pkg::core_in_t   core_in,
	output logic                   core_reset,
	output logic                   rom_loaded,
	output logic                   gp_ack,
	output logic [15:0]            gp_rdata
);

	arcade_pkg::mem_req_t   ld_req;
	arcade_pkg::mem_req_t   gp_req;
	arcade_pkg::mem_req_t   mem_cmd;
	arcade_pkg::mouse_pos_t m0;
	arcade_pkg::mouse_pos_t m1;
	logic                   ld_req_valid;
	logic                   mem_cmd_valid;
	logic [15:0]            mem_rdata;

	// ROM 0000-8FFF stays low, D000-FFFF folds down to 9000, RAM goes in the top half
	assign gp_req.addr = gp_rom_sel ?
		{1'b0, gp_addr[16], ~gp_addr[16] & gp_addr[15], gp_addr[14:1]} :
		{1'b1, gp_addr[16:1]};
	assign gp_req.we = gp_we;
	assign gp_req.ds = gp_ds;
	assign gp_req.data = gp_wdata;

	rom_loader u_loader (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_index, .dl_addr, .dl_data,
		.status_reset, .button_reset, .ld_req, .ld_req_valid, .rom_loaded, .core_reset
	);

	mem_arbiter u_arbiter (
		.clk_sys, .reset, .ld_req, .ld_req_valid, .gp_req, .gp_req_valid(gp_valid),
		.mem_rdata, .mem_cmd, .mem_cmd_valid, .ld_ack(), .gp_ack, .gp_rdata
	);

	game_mem u_mem (.clk_sys, .cmd(mem_cmd), .cmd_valid(mem_cmd_valid), .rdata(mem_rdata));

	mouse_accum u_mouse (
		.clk_sys, .reset, .strobe(mouse_strobe), .idx(mouse_idx),
		.dx(mouse_x), .dy(mouse_y), .flags(mouse_flags), .m0, .m1
	);

	control_mapper #(.adv_stretch(adv_stretch)) u_ctrl (
		.clk_sys, .reset, .game, .p1, .p2, .cab, .core_reset, .auto_up,
		.advance_req, .m0, .m1, .core_in
	);

endmodule

/* memory/game_mem.sv */
// Game memory
// 128K words with byte-lane writes, read data one cycle after the command

module game_mem (
	input  logic                 clk_sys,
	input  arcade_pkg::mem_req_t cmd,
	input  logic                 cmd_valid,
	output logic [15:0]          rdata
);

	logic [15:0] mem [0:(2**arcade_pkg::mem_addr_w)-1];

	always_ff @(posedge clk_sys) begin
		if (cmd_valid) begin
			if (cmd.we && cmd.ds[1])
				mem[cmd.addr][15:8] <= cmd.data[15:8];
			if (cmd.we && cmd.ds[0])
				mem[cmd.addr][7:0] <= cmd.data[7:0];
			rdata <= mem[cmd.addr]; // Old word on a write
		end
	end

endmodule

/* memory/mem_arbiter.sv */
// Memory arbiter
// Loader and game port share one memory, loader wins a tie

module mem_arbiter (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  arcade_pkg::mem_req_t ld_req,
	input  logic                 ld_req_valid,
	input  arcade_pkg::mem_req_t gp_req,
	input  logic                 gp_req_valid,
	input  logic [15:0]          mem_rdata,
	output arcade_pkg::mem_req_t mem_cmd,
	output logic                 mem_cmd_valid,
	output logic                 ld_ack,
	output logic                 gp_ack,
	output logic [15:0]          gp_rdata
);

	arcade_pkg::mem_req_t gp_slot;
	arcade_pkg::mem_req_t gp_cur;
	logic                 gp_pend;
	logic                 gp_has;
	logic                 issue_ld;
	logic                 issue_gp;

	// A fresh request goes straight through when nothing waits
	assign gp_cur = gp_pend ? gp_slot : gp_req;
	assign gp_has = gp_pend | gp_req_valid;

	// Loader never waits, so it needs no slot
	assign issue_ld = ld_req_valid;
	assign issue_gp = gp_has & ~ld_req_valid;

	assign mem_cmd = issue_ld ? ld_req : gp_cur;
	assign mem_cmd_valid = issue_ld | issue_gp;
	assign gp_rdata = mem_rdata; // Memory output is already registered

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gp_pend <= 1'b0;
			ld_ack <= 1'b0;
			gp_ack <= 1'b0;
		end else begin
			gp_pend <= gp_has & ~issue_gp;
			ld_ack <= issue_ld; // Owner of the access now in memory
			gp_ack <= issue_gp;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (gp_req_valid)
			gp_slot <= gp_req;
	end

endmodule

/* memory/rom_loader.sv */
// ROM loader
// Turns download bytes into nibble-doubled memory writes and holds the core in reset

module rom_loader (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 dl_active,
	input  logic                 dl_wr,
	input  logic [7:0]           dl_index,
	input  logic [22:0]          dl_addr,
	input  logic [7:0]           dl_data,
	input  logic                 status_reset,
	input  logic                 button_reset,
	output arcade_pkg::mem_req_t ld_req,
	output logic                 ld_req_valid,
	output logic                 rom_loaded,
	output logic                 core_reset
);

	logic                              dl_wr_d;
	logic                              dl_active_d;
	logic                              is_cmos;
	logic [arcade_pkg::mem_addr_w-1:0] word_addr;

	// CMOS image sits at D000-D3FF in the ROM set, or comes alone on index FF
	assign is_cmos = (dl_index == 8'h00 && dl_addr[22:10] == 13'h34) || dl_index == 8'hff;
	assign word_addr = is_cmos ? arcade_pkg::cmos_base + {7'd0, dl_addr[9:0]} : dl_addr[16:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wr_d <= 1'b0;
			dl_active_d <= 1'b0;
			ld_req_valid <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			dl_wr_d <= dl_wr;
			dl_active_d <= dl_active;
			ld_req_valid <= dl_active & dl_wr & ~dl_wr_d;
			if (dl_active_d & ~dl_active)
				rom_loaded <= 1'b1; // Download finished
			core_reset <= status_reset | button_reset | dl_active | ~rom_loaded;
		end
	end

	always_ff @(posedge clk_sys) begin
		ld_req.addr <= word_addr;
		ld_req.we <= 1'b1;
		ld_req.ds <= 2'b11;
		ld_req.data <= {dl_data[7:4], dl_data[7:4], dl_data[3:0], dl_data[3:0]};
	end

endmodule

/* rtl/mouse_accum.sv */
// Mouse accumulator
// Two trackball positions built from relative mouse movement

module mouse_accum (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   strobe,
	input  logic                   idx,
	input  logic signed [8:0]      dx,
	input  logic signed [8:0]      dy,
	input  logic [7:0]             flags,
	output arcade_pkg::mouse_pos_t m0,
	output arcade_pkg::mouse_pos_t m1
);

	logic [9:0] dx_ext;
	logic [9:0] dy_ext;

	assign dx_ext = {dx[8], dx};
	assign dy_ext = {dy[8], dy};

	// Positions wrap at 10 bits
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m0 <= '0;
			m1 <= '0;
		end else if (strobe) begin
			if (!idx) begin
				m0.x <= m0.x + dx_ext;
				m0.y <= m0.y + dy_ext;
				m0.btn <= flags[1:0];
			end else begin
				m1.x <= m1.x + dx_ext;
				m1.y <= m1.y + dy_ext;
				m1.btn <= flags[1:0];
			end
		end
	end

endmodule

/* rtl/control_mapper.sv */
// Control mapper
// Builds the core's switch, joystick, button and analog inputs per game

module control_mapper #(
	parameter logic [23:0] adv_stretch = 24'hfffff
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  arcade_pkg::game_e     game,
	input  arcade_pkg::player_t   p1,
	input  arcade_pkg::player_t   p2,
	input  arcade_pkg::cab_ctrl_t cab,
	input  logic                  core_reset,
	input  logic                  auto_up,
	input  logic                  advance_req,
	input  arcade_pkg::mouse_pos_t m0,
	input  arcade_pkg::mouse_pos_t m1,
	output arcade_pkg::core_in_t  core_in
);

	logic        adv_d;
	logic [23:0] adv_cnt;
	logic        advance;
	logic        sin_x;
	logic        sin_y;
	logic        coin;
	logic [7:0]  twin_stick;

	assign advance = (adv_cnt != 24'd0);
	assign coin = cab.coin1 | cab.coin2;

	// Fire directions from the second stick, MAME style
	assign twin_stick = ~{p1.fire_d | p2.right, p1.fire_c | p2.left,
		p1.fire_b | p2.down, p1.fire_a | p2.up, p1.right, p1.left, p1.down, p1.up};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			adv_d <= 1'b0;
			adv_cnt <= 24'd0;
			sin_x <= 1'b0;
			sin_y <= 1'b0;
		end else begin
			adv_d <= advance_req;
			if (advance_req & ~adv_d)
				adv_cnt <= adv_stretch;
			else if (advance)
				adv_cnt <= adv_cnt - 24'd1;

			// Sinistar stick keeps the last direction
			if (p1.right | p2.right)
				sin_x <= 1'b0;
			else if (p1.left | p2.left)
				sin_x <= 1'b1;
			if (p1.up | p2.up)
				sin_y <= 1'b0;
			else if (p1.down | p2.down)
				sin_y <= 1'b1;
		end
	end

	always_comb begin
		core_in.sw = {6'h00, advance, auto_up};
		core_in.ja = 8'hff;
		core_in.jb = 8'hff;
		core_in.btn = {cab.two_players, cab.one_player, coin, core_reset};
		core_in.an0 = 8'h80;
		core_in.an1 = 8'h80;
		core_in.an2 = 8'h80;
		core_in.an3 = 8'h80;
		core_in.blitter_sc2 = 1'b0;
		core_in.sinistar = 1'b0;
		core_in.speedball = 1'b0;
		core_in.speech_en = 1'b0;
		core_in.orientation = 2'b10;

		case (game)
			arcade_pkg::robotron, arcade_pkg::splat: begin
				core_in.blitter_sc2 = (game == arcade_pkg::splat);
				core_in.btn = {cab.one_player, cab.two_players, coin, core_reset};
				core_in.ja = twin_stick;
				core_in.jb = twin_stick;
			end
			arcade_pkg::joust: begin
				core_in.ja = ~{5'b00000, p1.fire_a, p1.right, p1.left};
				core_in.jb = ~{5'b00000, p2.fire_a, p2.right, p2.left};
			end
			arcade_pkg::bubbles: begin
				core_in.ja = ~{4'b0000, p1.right, p1.left, p1.down, p1.up};
				core_in.jb = ~{4'b0000, p2.right, p2.left, p2.down, p2.up};
			end
			arcade_pkg::stargate: begin // Thrust, up, down, reverse, fire, smart bomb, hyper
				core_in.ja = ~{p1.fire_e, p1.up, p1.down, p1.left | p1.right,
					p1.fire_d, p1.fire_c, p1.fire_b, p1.fire_a};
				core_in.jb = ~{p2.fire_e, p2.up, p2.down, p2.left | p2.right,
					p2.fire_d, p2.fire_c, p2.fire_b, p2.fire_a};
			end
			arcade_pkg::alienar: begin
				core_in.btn = {cab.one_player, cab.two_players, coin, core_reset};
				core_in.ja = ~{2'b00, p1.fire_b, p1.fire_a, p1.right, p1.left, p1.down, p1.up};
				core_in.jb = ~{2'b00, p2.fire_b, p2.fire_a, p2.right, p2.left, p2.down, p2.up};
			end
			arcade_pkg::sinistar: begin
				core_in.sinistar = 1'b1;
				core_in.speech_en = 1'b1;
				core_in.orientation = 2'b01;
				core_in.ja = {sin_x, 2'b00, p1.right | p1.left | p2.right | p2.left,
					sin_y, 2'b00, p1.up | p1.down | p2.up | p2.down};
				core_in.jb = core_in.ja;
			end
			arcade_pkg::playball: begin
				core_in.speech_en = 1'b1;
				core_in.orientation = 2'b01;
				core_in.btn = {2'b00, coin, core_reset};
				core_in.ja = ~{4'b0000, cab.two_players, p1.right, p1.left, cab.one_player};
				core_in.jb = core_in.ja;
			end
			arcade_pkg::lottofun: begin
				core_in.btn = {cab.one_player | p1.fire_a, 1'b0, coin, core_reset};
				core_in.ja = ~{4'b0000, p1.right, p1.left, p1.down, p1.up};
			end
			arcade_pkg::speedball: begin
				core_in.speedball = 1'b1;
				core_in.ja = {p1.fire_d, p1.fire_c, p1.fire_b, p1.fire_a | m0.btn[0],
					p1.right, p1.left, p1.down, p1.up};
				core_in.jb = {p2.fire_d, p2.fire_c, p2.fire_b, p2.fire_a | m1.btn[0],
					p2.right, p2.left, p2.down, p2.up};
				core_in.an0 = {~m0.y[8], m0.y[7:1]}; // Trackball as offset binary
				core_in.an1 = {~m0.x[8], m0.x[7:1]};
				core_in.an2 = {~m1.y[8], m1.y[7:1]};
				core_in.an3 = {~m1.x[8], m1.x[7:1]};
			end
			default: ;
		endcase
	end

endmodule

/* common/arcade_pkg.sv */
// Shared types for the arcade board glue
// Player controls, memory requests, core inputs and game codes

package arcade_pkg;

	localparam int mem_addr_w = 17; // Word address width of game memory
	localparam logic [mem_addr_w-1:0] cmos_base = 17'h1CC00;

	// Selected game, from the menu
	typedef enum logic [6:0] {
		robotron  = 7'd0,
		joust     = 7'd1,
		splat     = 7'd2,
		bubbles   = 7'd3,
		stargate  = 7'd4,
		alienar   = 7'd5,
		sinistar  = 7'd6,
		playball  = 7'd7,
		lottofun  = 7'd8,
		speedball = 7'd9
	} game_e;

	// One player, active high
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic fire_e;
		logic fire_f;
	} player_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic one_player;
		logic two_players;
	} cab_ctrl_t;

	typedef struct packed {
		logic signed [9:0] x;
		logic signed [9:0] y;
		logic [1:0]        btn;
	} mouse_pos_t;

	// Everything the game core samples
	typedef struct packed {
		logic [7:0] sw;
		logic [7:0] ja;
		logic [7:0] jb;
		logic [3:0] btn;
		logic [7:0] an0;
		logic [7:0] an1;
		logic [7:0] an2;
		logic [7:0] an3;
		logic       blitter_sc2;
		logic       sinistar;
		logic       speedball;
		logic       speech_en;
		logic [1:0] orientation; // Left/right, landscape/portrait
	} core_in_t;

	typedef struct packed {
		logic [mem_addr_w-1:0] addr;
		logic                  we;
		logic [1:0]            ds; // Upper, lower byte
		logic [15:0]           data;
	} mem_req_t;

endpackage
